// File: verification/dma_input.txt
// each record is 8 words: type then arguments, unused words are 0
// 0 sizes: dsc_size pkt_size | 1 queue: q dsc_head dsc_tail dsc_base pkt_head pkt_tail pkt_base
// 2 packet: q size seed | 3 head advance: q pkt_head | 4 final: q dsc_tail pkt_tail
// 5 waitrequest: 1 random, 0 low | ff end
0 10 40 0 0 0 0 0
1 3 0 0 10000000 0 0 20000000
1 7 0 e 30000000 0 30 40000000
5 1 0 0 0 0 0 0
2 3 1 a1 0 0 0 0
2 7 8 b2 0 0 0 0
2 3 9 c3 0 0 0 0
2 3 11 d4 0 0 0 0
5 0 0 0 0 0 0 0
2 7 9 e5 0 0 0 0
3 7 38 0 0 0 0 0
2 3 2 f6 0 0 0 0
4 3 4 1d 0 0 0 0
4 7 0 0 0 0 0 0
ff 0 0 0 0 0 0 0

// File: src.f
+incdir+common
common/dma_pkg.sv
src/dma_fifo.sv
dma_engine/queue_fetch.sv
dma_engine/space_check.sv
dma_engine/burst_writer.sv
src/fpga2cpu_dma.sv
verification/dma_assert.sv
verification/tb_fpga2cpu_dma.sv

// File: run.sh
#!/bin/sh
# build and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_fpga2cpu_dma -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: verification/tb_fpga2cpu_dma.sv
`timescale 1ns/10ps
`default_nettype none
`include "dma_consts.svh"

module tb_fpga2cpu_dma
    import dma_pkg::*;
;

    logic clk;
    logic rst;
    flit_t pkt_wr_data;
    logic pkt_wr_en;
    pkt_desc_t desc_wr_data;
    logic desc_wr_en;
    logic [`DMA_QID_WIDTH-1:0] rd_queue;
    logic queue_rd_en;
    queue_state_t queue_state;
    logic queue_ready;
    logic [`DMA_QID_WIDTH-1:0] wr_queue;
    logic [`DMA_RB_AWIDTH-1:0] out_dsc_tail;
    logic [`DMA_RB_AWIDTH-1:0] out_pkt_tail;
    logic tail_wr_en;
    logic [30:0] dsc_rb_size;
    logic [30:0] pkt_rb_size;
    logic waitreq;
    bas_req_t bas;
    logic [31:0] dma_queue_full_cnt;
    logic [31:0] cpu_buf_full_cnt;

    // queue table model and its read responder
    queue_state_t table_q [32];
    logic rd_pending;
    logic [2:0] rd_delay;
    logic [`DMA_QID_WIDTH-1:0] rd_q;

    // expected bus traffic, built from the address and wrap rules
    logic [63:0] exp_addr [$];
    logic [511:0] exp_data [$];
    logic [3:0] exp_bc [$];
    logic [4:0] exp_tq [$];
    logic [15:0] exp_dt [$];
    logic [15:0] exp_pt [$];
    logic [15:0] trk_dsc_tail [32];
    logic [15:0] trk_pkt_tail [32];

    logic [63:0] stim [0:255];
    logic wait_mode;
    int cycles;
    int limit;

    fpga2cpu_dma i_dut (
        .clk(clk), .rst(rst),
        .pkt_wr_data(pkt_wr_data), .pkt_wr_en(pkt_wr_en),
        .desc_wr_data(desc_wr_data), .desc_wr_en(desc_wr_en),
        .rd_queue(rd_queue), .queue_rd_en(queue_rd_en),
        .queue_state(queue_state), .queue_ready(queue_ready),
        .wr_queue(wr_queue), .out_dsc_tail(out_dsc_tail),
        .out_pkt_tail(out_pkt_tail), .tail_wr_en(tail_wr_en),
        .dsc_rb_size(dsc_rb_size), .pkt_rb_size(pkt_rb_size),
        .pcie_bas_waitrequest(waitreq), .bas(bas),
        .dma_queue_full_cnt(dma_queue_full_cnt), .cpu_buf_full_cnt(cpu_buf_full_cnt)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [15:0] wrap_tail(input logic [15:0] t, input logic [15:0] step,
                                              input logic [30:0] size);
        logic [31:0] s;
        s = 32'(t) + 32'(step);
        if (s >= 32'(size)) begin
            return 16'd0;
        end
        return s[15:0];
    endfunction

    // flit payload depends on packet seed, flit index and lane
    function automatic logic [511:0] flit_pattern(input logic [31:0] seed, input int idx);
        logic [511:0] d;
        for (int l = 0; l < 16; l++) begin
            d[l*32 +: 32] = seed * 32'h9e3779b1 + 32'(idx) * 32'h00010001 + 32'(l);
        end
        return d;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            report_error($sformatf("timeout: no progress after %0d cycles", cycles));
        end
    end

    always @(posedge clk) begin
        waitreq <= wait_mode ? ($urandom % 3 == 0) : 1'b0;
    end

    always @(posedge clk) begin
        queue_ready <= 1'b0;
        if (rd_pending) begin
            if (rd_delay == 3'd1) begin
                queue_ready <= 1'b1;
                queue_state <= table_q[rd_q];
                rd_pending <= 1'b0;
            end else begin
                rd_delay <= rd_delay - 3'd1;
            end
        end
        if (queue_rd_en) begin
            rd_pending <= 1'b1;
            rd_q <= rd_queue;
            rd_delay <= 3'(1 + $urandom % 4);
        end
        if (tail_wr_en) begin
            table_q[wr_queue].dsc_tail <= out_dsc_tail;
            table_q[wr_queue].pkt_tail <= out_pkt_tail;
        end
    end

    // scoreboard on accepted beats and tail write-backs
    always @(posedge clk) begin
        if (!rst && bas.write && !waitreq) begin
            assert (exp_addr.size() != 0)
            else report_error($sformatf("unexpected write to %h at %0t", bas.address, $time));
            assert (bas.address == exp_addr[0] && bas.writedata == exp_data[0]
                    && bas.burstcount == exp_bc[0] && bas.byteenable == '1)
            else report_error($sformatf("Error at %0t: beat addr %h bc %0d, expected %h bc %0d",
                                        $time, bas.address, bas.burstcount,
                                        exp_addr[0], exp_bc[0]));
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_bc.pop_front());
        end
        if (!rst && tail_wr_en) begin
            assert (exp_tq.size() != 0)
            else report_error($sformatf("unexpected tail write at %0t", $time));
            assert (wr_queue == exp_tq[0] && out_dsc_tail == exp_dt[0]
                    && out_pkt_tail == exp_pt[0])
            else report_error($sformatf("Error at %0t: tails q%0d %0d/%0d, expected q%0d %0d/%0d",
                                        $time, wr_queue, out_dsc_tail, out_pkt_tail,
                                        exp_tq[0], exp_dt[0], exp_pt[0]));
            void'(exp_tq.pop_front());
            void'(exp_dt.pop_front());
            void'(exp_pt.pop_front());
        end
    end

    task automatic send_packet(input logic [4:0] q, input logic [15:0] size,
                               input logic [31:0] seed);
        logic [15:0] npt;
        logic [15:0] ndt;
        logic [511:0] d;
        for (int i = 0; i < int'(size); i++) begin
            exp_addr.push_back(table_q[q].pkt_buf_addr
                               + 64'd64 * (64'(trk_pkt_tail[q]) + 64'(i)));
            exp_data.push_back(flit_pattern(seed, i));
            if (i % 8 == 0) begin
                exp_bc.push_back((int'(size) - i > 8) ? 4'd8 : 4'(int'(size) - i));
            end else begin
                exp_bc.push_back(4'd0);
            end
        end
        npt = wrap_tail(trk_pkt_tail[q], size, pkt_rb_size);
        ndt = wrap_tail(trk_dsc_tail[q], 16'd1, dsc_rb_size);
        d = '0;
        d[0] = 1'b1;
        d[32:1] = 32'(npt);
        d[37:33] = q;
        exp_addr.push_back(table_q[q].dsc_buf_addr + 64'd64 * 64'(trk_dsc_tail[q]));
        exp_data.push_back(d);
        exp_bc.push_back(4'd1);
        exp_tq.push_back(q);
        exp_dt.push_back(ndt);
        exp_pt.push_back(npt);
        trk_pkt_tail[q] = npt;
        trk_dsc_tail[q] = ndt;
        for (int i = 0; i < int'(size); i++) begin
            @(posedge clk);
            pkt_wr_en <= 1'b1;
            pkt_wr_data.data <= flit_pattern(seed, i);
            pkt_wr_data.sop <= (i == 0);
            pkt_wr_data.eop <= (i == int'(size) - 1);
        end
        @(posedge clk);
        pkt_wr_en <= 1'b0;
        desc_wr_en <= 1'b1;
        desc_wr_data.queue_id <= q;
        desc_wr_data.size <= size;
        @(posedge clk);
        desc_wr_en <= 1'b0;
    endtask

    // queues are looked at between edges, once the scoreboard has settled
    task automatic drain();
        while (exp_addr.size() != 0 || exp_tq.size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        int p;
        int npkts;
        logic [4:0] q;
        logic saw_random;
        logic [31:0] snap;
        void'($urandom(74));
        rst = 1'b1;
        pkt_wr_en = 1'b0;
        pkt_wr_data = '0;
        desc_wr_en = 1'b0;
        desc_wr_data = '0;
        queue_state = '0;
        queue_ready = 1'b0;
        dsc_rb_size = '0;
        pkt_rb_size = '0;
        waitreq = 1'b0;
        wait_mode = 1'b0;
        rd_pending = 1'b0;
        rd_delay = '0;
        rd_q = '0;
        cycles = 0;
        limit = 0;
        saw_random = 1'b0;
        snap = '0;
        for (int i = 0; i < 32; i++) begin
            table_q[i] = '0;
            trk_dsc_tail[i] = '0;
            trk_pkt_tail[i] = '0;
        end
        $readmemh("verification/dma_input.txt", stim);
        npkts = 0;
        for (p = 0; p < 256 && stim[p][7:0] != 8'hff; p += 8) begin
            if (stim[p][7:0] == 8'h02) begin
                npkts++;
            end
        end
        limit = 200 * npkts + 1000;

        repeat (5) @(posedge clk);
        assert (!queue_rd_en && !tail_wr_en && !bas.write
                && dma_queue_full_cnt == 0 && cpu_buf_full_cnt == 0)
        else report_error($sformatf("Error at %0t: outputs not idle in reset", $time));
        rst <= 1'b0;

        for (p = 0; p < 256 && stim[p][7:0] != 8'hff; p += 8) begin
            q = stim[p+1][4:0];
            case (stim[p][7:0])
                8'h00: begin
                    dsc_rb_size <= stim[p+1][30:0];
                    pkt_rb_size <= stim[p+2][30:0];
                    @(posedge clk);
                end
                8'h01: begin
                    table_q[q].dsc_head = stim[p+2][15:0];
                    table_q[q].dsc_tail = stim[p+3][15:0];
                    table_q[q].dsc_buf_addr = stim[p+4];
                    table_q[q].pkt_head = stim[p+5][15:0];
                    table_q[q].pkt_tail = stim[p+6][15:0];
                    table_q[q].pkt_buf_addr = stim[p+7];
                    trk_dsc_tail[q] = stim[p+3][15:0];
                    trk_pkt_tail[q] = stim[p+6][15:0];
                end
                8'h02: send_packet(q, stim[p+2][15:0], stim[p+3][31:0]);
                8'h03: begin
                    // the packet must sit blocked until the head moves
                    while (cpu_buf_full_cnt == 0) begin
                        @(posedge clk);
                    end
                    repeat (20) @(posedge clk);
                    assert (exp_tq.size() == 1)
                    else report_error($sformatf("Error at %0t: blocked packet was written",
                                                $time));
                    table_q[q].pkt_head <= stim[p+2][15:0];
                    // the CPU has also consumed every completion entry written so far
                    table_q[q].dsc_head <= table_q[q].dsc_tail;
                end
                8'h04: begin
                    drain();
                    repeat (4) @(posedge clk);
                    assert (table_q[q].dsc_tail == stim[p+2][15:0]
                            && table_q[q].pkt_tail == stim[p+3][15:0])
                    else report_error($sformatf("Error at %0t: q%0d final tails %0d/%0d",
                                                $time, q, table_q[q].dsc_tail,
                                                table_q[q].pkt_tail));
                    assert (cpu_buf_full_cnt != 0)
                    else report_error("ring-full counter never counted");
                    assert (wait_mode || dma_queue_full_cnt == snap)
                    else report_error($sformatf("Error at %0t: stall counter moved", $time));
                end
                8'h05: begin
                    drain();
                    assert (!(saw_random && dma_queue_full_cnt == 0))
                    else report_error("stall counter stayed 0 under random waitrequest");
                    saw_random = saw_random | stim[p+1][0];
                    wait_mode <= stim[p+1][0];
                    @(posedge clk);
                    @(posedge clk);
                    snap = dma_queue_full_cnt;
                end
                default: report_error($sformatf("bad record type at word %0d", p));
            endcase
        end
        drain();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/dma_assert.sv
`timescale 1ns/10ps
`default_nettype none
`include "dma_consts.svh"

module dma_assert
    import dma_pkg::*;
(
    input wire           clk,
    input wire           rst,
    input wire           pcie_bas_waitrequest,
    input wire bas_req_t bas,
    input wire           tail_wr_en
);

    // the master may not change a request it is stalling
    bas_hold: assert property (@(posedge clk) disable iff (rst)
        pcie_bas_waitrequest |=> $stable(bas))
    else $error("bas changed under waitrequest");

    burst_max: assert property (@(posedge clk) disable iff (rst)
        bas.write |-> bas.burstcount <= 4'(`DMA_MAX_BURST))
    else $error("burstcount above limit");

    tail_pulse: assert property (@(posedge clk) disable iff (rst)
        tail_wr_en |=> !tail_wr_en)
    else $error("tail_wr_en longer than one cycle");

endmodule

bind burst_writer dma_assert i_dma_assert (
    .clk                  (clk),
    .rst                  (rst),
    .pcie_bas_waitrequest (pcie_bas_waitrequest),
    .bas                  (bas),
    .tail_wr_en           (tail_wr_en)
);

`default_nettype wire

// File: src/fpga2cpu_dma.sv
`timescale 1ns/10ps
`default_nettype none
`include "dma_consts.svh"

module fpga2cpu_dma
    import dma_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst,

    // packet and descriptor inputs
    input  wire flit_t                 pkt_wr_data,
    input  wire                        pkt_wr_en,
    input  wire pkt_desc_t             desc_wr_data,
    input  wire                        desc_wr_en,

    // queue table
    output logic [`DMA_QID_WIDTH-1:0]  rd_queue,
    output logic                       queue_rd_en,
    input  wire queue_state_t          queue_state,
    input  wire                        queue_ready,
    output logic [`DMA_QID_WIDTH-1:0]  wr_queue,
    output logic [`DMA_RB_AWIDTH-1:0]  out_dsc_tail,
    output logic [`DMA_RB_AWIDTH-1:0]  out_pkt_tail,
    output logic                       tail_wr_en,

    input  wire [30:0]                 dsc_rb_size,
    input  wire [30:0]                 pkt_rb_size,

    // PCIe burst master
    input  wire                        pcie_bas_waitrequest,
    output bas_req_t                   bas,

    output logic [31:0]                dma_queue_full_cnt,
    output logic [31:0]                cpu_buf_full_cnt
);

    flit_t     pkt_rd;
    logic      pkt_avail;
    logic      pkt_pop;
    pkt_desc_t desc_rd;
    logic      desc_avail;
    logic      desc_pop;
    dma_job_t  fetched_job;
    logic      fetched_valid;
    dma_job_t  ready_job;
    logic      job_start;
    logic      refetch;
    logic      job_done;

    dma_fifo #(
        .payload_t (flit_t),
        .DEPTH     (`DMA_FIFO_DEPTH),
        .AWIDTH    (`DMA_FIFO_AWIDTH)
    ) i_pkt_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_data   (pkt_wr_data),
        .wr_en     (pkt_wr_en),
        .rd_data   (pkt_rd),
        .rd_en     (pkt_pop),
        .not_empty (pkt_avail)
    );

    // sized for the worst case of all single-flit packets
    dma_fifo #(
        .payload_t (pkt_desc_t),
        .DEPTH     (`DMA_FIFO_DEPTH),
        .AWIDTH    (`DMA_FIFO_AWIDTH)
    ) i_desc_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_data   (desc_wr_data),
        .wr_en     (desc_wr_en),
        .rd_data   (desc_rd),
        .rd_en     (desc_pop),
        .not_empty (desc_avail)
    );

    queue_fetch i_queue_fetch (
        .clk           (clk),
        .rst           (rst),
        .desc          (desc_rd),
        .desc_avail    (desc_avail),
        .desc_pop      (desc_pop),
        .rd_queue      (rd_queue),
        .queue_rd_en   (queue_rd_en),
        .queue_state   (queue_state),
        .queue_ready   (queue_ready),
        .refetch       (refetch),
        .job_done      (job_done),
        .fetched_job   (fetched_job),
        .fetched_valid (fetched_valid)
    );

    space_check i_space_check (
        .clk              (clk),
        .rst              (rst),
        .fetched_job      (fetched_job),
        .fetched_valid    (fetched_valid),
        .dsc_rb_size      (dsc_rb_size),
        .pkt_rb_size      (pkt_rb_size),
        .ready_job        (ready_job),
        .job_start        (job_start),
        .refetch          (refetch),
        .cpu_buf_full_cnt (cpu_buf_full_cnt)
    );

    burst_writer i_burst_writer (
        .clk                  (clk),
        .rst                  (rst),
        .ready_job            (ready_job),
        .job_start            (job_start),
        .flit                 (pkt_rd),
        .flit_avail           (pkt_avail),
        .flit_pop             (pkt_pop),
        .pcie_bas_waitrequest (pcie_bas_waitrequest),
        .bas                  (bas),
        .dsc_rb_size          (dsc_rb_size),
        .pkt_rb_size          (pkt_rb_size),
        .wr_queue             (wr_queue),
        .out_dsc_tail         (out_dsc_tail),
        .out_pkt_tail         (out_pkt_tail),
        .tail_wr_en           (tail_wr_en),
        .job_done             (job_done),
        .dma_queue_full_cnt   (dma_queue_full_cnt)
    );

endmodule

`default_nettype wire

// File: dma_engine/burst_writer.sv
`timescale 1ns/10ps
`default_nettype none
`include "dma_consts.svh"

module burst_writer
    import dma_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst,

    input  wire dma_job_t              ready_job,
    input  wire                        job_start,

    // packet FIFO
    input  wire flit_t                 flit,
    input  wire                        flit_avail,
    output logic                       flit_pop,

    // PCIe burst master
    input  wire                        pcie_bas_waitrequest,
    output bas_req_t                   bas,

    input  wire [30:0]                 dsc_rb_size,
    input  wire [30:0]                 pkt_rb_size,

    // tail write-back
    output logic [`DMA_QID_WIDTH-1:0]  wr_queue,
    output logic [`DMA_RB_AWIDTH-1:0]  out_dsc_tail,
    output logic [`DMA_RB_AWIDTH-1:0]  out_pkt_tail,
    output logic                       tail_wr_en,
    output logic                       job_done,

    output logic [31:0]                dma_queue_full_cnt
);

    typedef enum logic [1:0] {
        IDLE,
        START_BURST,
        CONTINUE_BURST,
        COMPLETE
    } state_t;

    state_t                     state;
    dma_job_t                   cur_job;
    logic [`DMA_SIZE_WIDTH-1:0] flits_left;
    logic [3:0]                 burst_left;

    dma_job_t                   job;
    logic [`DMA_SIZE_WIDTH-1:0] left;
    logic [`DMA_SIZE_WIDTH-1:0] flit_idx;
    logic [3:0]                 first_count;
    logic [3:0]                 beats_after;
    logic                       first;
    logic                       issue;
    logic [63:0]                beat_addr;
    logic [`DMA_RB_AWIDTH-1:0]  new_dsc_tail;
    logic [`DMA_RB_AWIDTH-1:0]  new_pkt_tail;
    cpu_desc_t                  cpu_desc;

    // advance a ring pointer, restarting at 0 once it reaches the ring size
    function automatic logic [`DMA_RB_AWIDTH-1:0] next_ptr(
        input logic [`DMA_RB_AWIDTH-1:0]  ptr,
        input logic [`DMA_SIZE_WIDTH-1:0] step,
        input logic [30:0]                size
    );
        logic [31:0] sum;
        sum = 32'(ptr) + 32'(step);
        if (sum >= 32'(size)) begin
            return '0;
        end
        return sum[`DMA_RB_AWIDTH-1:0];
    endfunction

    // in IDLE the first beat is taken straight from the incoming job
    assign job = (state == IDLE) ? ready_job : cur_job;
    assign left = (state == IDLE) ? ready_job.desc.size : flits_left;
    assign flit_idx = job.desc.size - left;

    assign first = (state != CONTINUE_BURST);
    assign first_count = (left > `DMA_MAX_BURST) ? 4'(`DMA_MAX_BURST) : left[3:0];
    assign beats_after = first ? (first_count - 4'd1) : (burst_left - 4'd1);

    assign beat_addr = job.qstate.pkt_buf_addr
                     + 64'(`DMA_FLIT_BYTES) * (64'(job.qstate.pkt_tail) + 64'(flit_idx));

    assign issue = flit_avail && !pcie_bas_waitrequest
                && ((state == IDLE && job_start)
                    || state == START_BURST
                    || state == CONTINUE_BURST);
    assign flit_pop = issue;

    assign new_dsc_tail = next_ptr(cur_job.qstate.dsc_tail, `DMA_SIZE_WIDTH'(1), dsc_rb_size);
    assign new_pkt_tail = next_ptr(cur_job.qstate.pkt_tail, cur_job.desc.size, pkt_rb_size);

    always_comb begin
        cpu_desc = '0;
        cpu_desc.signal = 1'b1;
        cpu_desc.tail = 32'(new_pkt_tail);
        cpu_desc.queue_id = cur_job.desc.queue_id;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            bas.write <= 1'b0;
            tail_wr_en <= 1'b0;
            job_done <= 1'b0;
            dma_queue_full_cnt <= '0;
        end else begin
            tail_wr_en <= 1'b0;
            job_done <= 1'b0;

            // bas may only move while the master is not stalling
            if (pcie_bas_waitrequest) begin
                if (bas.write) begin
                    dma_queue_full_cnt <= dma_queue_full_cnt + 32'd1;
                end
            end else begin
                bas.write <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (job_start) begin
                        cur_job <= ready_job;
                        flits_left <= ready_job.desc.size;
                        state <= START_BURST;
                    end
                end
                COMPLETE: begin
                    // data is all accepted, post the completion entry
                    if (!pcie_bas_waitrequest) begin
                        bas.address <= cur_job.qstate.dsc_buf_addr
                                     + 64'(`DMA_FLIT_BYTES) * 64'(cur_job.qstate.dsc_tail);
                        bas.byteenable <= '1;
                        bas.write <= 1'b1;
                        bas.writedata <= cpu_desc;
                        bas.burstcount <= 4'd1;
                        wr_queue <= cur_job.desc.queue_id;
                        out_dsc_tail <= new_dsc_tail;
                        out_pkt_tail <= new_pkt_tail;
                        tail_wr_en <= 1'b1;
                        job_done <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: begin
                end
            endcase

            if (issue) begin
                bas.address <= beat_addr;
                bas.byteenable <= '1;
                bas.write <= 1'b1;
                bas.writedata <= flit.data;
                // only the first beat of a burst carries its length
                bas.burstcount <= first ? first_count : 4'd0;
                flits_left <= left - 1'b1;
                burst_left <= beats_after;
                if (left == `DMA_SIZE_WIDTH'(1)) begin
                    state <= COMPLETE;
                end else if (beats_after == 4'd0) begin
                    state <= START_BURST;
                end else begin
                    state <= CONTINUE_BURST;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dma_engine/space_check.sv
`timescale 1ns/10ps
`default_nettype none
`include "dma_consts.svh"

module space_check
    import dma_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire dma_job_t fetched_job,
    input  wire           fetched_valid,
    input  wire [30:0]    dsc_rb_size,
    input  wire [30:0]    pkt_rb_size,
    output dma_job_t      ready_job,
    output logic          job_start,
    output logic          refetch,
    output logic [31:0]   cpu_buf_full_cnt
);

    logic [31:0] dsc_free;
    logic [31:0] pkt_free;
    logic        room;

    // one slot always stays empty so that head == tail means empty
    function automatic logic [31:0] free_slots(
        input logic [`DMA_RB_AWIDTH-1:0] head,
        input logic [`DMA_RB_AWIDTH-1:0] tail,
        input logic [30:0]               size
    );
        if (tail >= head) begin
            return 32'(size) - 32'(tail) + 32'(head) - 32'd1;
        end
        return 32'(head) - 32'(tail) - 32'd1;
    endfunction

    assign dsc_free = free_slots(fetched_job.qstate.dsc_head,
                                 fetched_job.qstate.dsc_tail, dsc_rb_size);
    assign pkt_free = free_slots(fetched_job.qstate.pkt_head,
                                 fetched_job.qstate.pkt_tail, pkt_rb_size);

    // whole packet plus its completion entry must fit
    assign room = (pkt_free >= 32'(fetched_job.desc.size)) && (dsc_free != 32'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            job_start <= 1'b0;
            refetch <= 1'b0;
            cpu_buf_full_cnt <= '0;
        end else begin
            job_start <= fetched_valid && room;
            refetch <= fetched_valid && !room;
            if (fetched_valid && !room) begin
                cpu_buf_full_cnt <= cpu_buf_full_cnt + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetched_valid) begin
            ready_job <= fetched_job;
        end
    end

endmodule

`default_nettype wire

// File: dma_engine/queue_fetch.sv
`timescale 1ns/10ps
`default_nettype none
`include "dma_consts.svh"

module queue_fetch
    import dma_pkg::*;
(
    input  wire                            clk,
    input  wire                            rst,

    // descriptor FIFO
    input  wire pkt_desc_t                 desc,
    input  wire                            desc_avail,
    output logic                           desc_pop,

    // queue table read
    output logic [`DMA_QID_WIDTH-1:0]      rd_queue,
    output logic                           queue_rd_en,
    input  wire queue_state_t              queue_state,
    input  wire                            queue_ready,

    // feedback from the later stages
    input  wire                            refetch,
    input  wire                            job_done,

    output dma_job_t                       fetched_job,
    output logic                           fetched_valid
);

    // one packet in flight at a time
    logic busy;
    logic waiting;

    assign desc_pop = !busy && desc_avail;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            waiting <= 1'b0;
            queue_rd_en <= 1'b0;
            fetched_valid <= 1'b0;
        end else begin
            queue_rd_en <= 1'b0;
            fetched_valid <= 1'b0;

            if (desc_pop) begin
                busy <= 1'b1;
                waiting <= 1'b1;
                queue_rd_en <= 1'b1;
                rd_queue <= desc.queue_id;
                fetched_job.desc <= desc;
            end

            // ring was full, read the same queue again for fresh heads
            if (refetch) begin
                waiting <= 1'b1;
                queue_rd_en <= 1'b1;
            end

            if (waiting && queue_ready) begin
                waiting <= 1'b0;
                fetched_job.qstate <= queue_state;
                fetched_valid <= 1'b1;
            end

            if (job_done) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dma_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "dma_consts.svh"

module dma_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `DMA_FIFO_DEPTH,
    parameter int  AWIDTH    = `DMA_FIFO_AWIDTH
) (
    input  wire           clk,
    input  wire           rst,
    input  wire payload_t wr_data,
    input  wire           wr_en,
    output payload_t      rd_data,
    input  wire           rd_en,
    output logic          not_empty
);

    payload_t mem [DEPTH];

    // one extra bit tells full from empty
    logic [AWIDTH:0] wr_ptr;
    logic [AWIDTH:0] rd_ptr;
    logic            full;
    logic            push;
    logic            pop;

    assign not_empty = (wr_ptr != rd_ptr);
    assign full = (wr_ptr[AWIDTH] != rd_ptr[AWIDTH])
               && (wr_ptr[AWIDTH-1:0] == rd_ptr[AWIDTH-1:0]);
    assign push = wr_en && !full;
    assign pop = rd_en && not_empty;

    // show-ahead: the head entry is always on rd_data
    assign rd_data = mem[rd_ptr[AWIDTH-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AWIDTH-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: common/dma_pkg.sv
`default_nettype none
`include "dma_consts.svh"

package dma_pkg;

    typedef struct packed {
        logic [`DMA_DATA_WIDTH-1:0] data;
        logic                       sop;
        logic                       eop;
    } flit_t;

    typedef struct packed {
        logic [`DMA_QID_WIDTH-1:0]  queue_id;
        logic [`DMA_SIZE_WIDTH-1:0] size;
    } pkt_desc_t;

    // ring state of one queue, as kept in the queue table
    typedef struct packed {
        logic [`DMA_RB_AWIDTH-1:0] dsc_head;
        logic [`DMA_RB_AWIDTH-1:0] dsc_tail;
        logic [63:0]               dsc_buf_addr;
        logic [`DMA_RB_AWIDTH-1:0] pkt_head;
        logic [`DMA_RB_AWIDTH-1:0] pkt_tail;
        logic [63:0]               pkt_buf_addr;
    } queue_state_t;

    typedef struct packed {
        pkt_desc_t    desc;
        queue_state_t qstate;
    } dma_job_t;

    typedef struct packed {
        logic [63:0]                address;
        logic [63:0]                byteenable;
        logic                       write;
        logic [`DMA_DATA_WIDTH-1:0] writedata;
        logic [3:0]                 burstcount;
    } bas_req_t;

    // completion entry written into the descriptor ring
    typedef struct packed {
        logic [`DMA_DATA_WIDTH-`DMA_QID_WIDTH-34:0] pad;
        logic [`DMA_QID_WIDTH-1:0]                  queue_id;
        logic [31:0]                                tail;
        logic                                       signal;
    } cpu_desc_t;

endpackage

`default_nettype wire

// File: common/dma_consts.svh
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// input FIFOs
`define DMA_FIFO_DEPTH 512
`define DMA_FIFO_AWIDTH 9

// CPU ring pointers and queue ids
`define DMA_RB_AWIDTH 16
`define DMA_QID_WIDTH 5

// one flit is one PCIe beat
`define DMA_DATA_WIDTH 512
`define DMA_FLIT_BYTES 64

// largest burst the PCIe master accepts
`define DMA_MAX_BURST 8

// packet size is counted in flits
`define DMA_SIZE_WIDTH 16

`endif
